//--- build.f
design/mem_pkg.sv
design/slot_cache.sv
design/slot_arbiter.sv
design/bank_port.sv
design/sdram_mux_top.sv
test/sdram_mux_props.sv
test/tb_sdram_mux.sv

//--- Bender.yml
package:
  name: sdram_mux

sources:
  - files:
      - design/mem_pkg.sv
      - design/slot_cache.sv
      - design/slot_arbiter.sv
      - design/bank_port.sv
      - design/sdram_mux_top.sv
  - target: test
    files:
      - test/sdram_mux_props.sv
      - test/tb_sdram_mux.sv

//--- test/tb_sdram_mux.sv
//********************
// Testbench for the SDRAM slot layer.
// Random client traffic on all four slots against an SDRAM
// controller model that keeps a reference memory.
//********************
`timescale 1ns/1ps

module tb_sdram_mux import mem_pkg::*; ();

    localparam int TXN_PER_SLOT = 200;
    localparam int CYCLE_LIMIT  = TXN_PER_SLOT * NUM_SLOTS * 20;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic [NUM_SLOTS-1:0] cs;
    slot_addr_t           addr [NUM_SLOTS];
    mem_data_t            dout [NUM_SLOTS];
    logic [NUM_SLOTS-1:0] ok;
    logic                 ram_wen;
    mem_data_t            ram_din;
    wr_mask_t             ram_mask;
    logic                 sdram_req;
    logic                 sdram_we;
    mem_addr_t            sdram_addr;
    mem_data_t            sdram_din;
    wr_mask_t             sdram_mask;
    logic                 sdram_ack;
    mem_data_t            sdram_rdata;

    mem_data_t ref_mem [mem_addr_t];  // Words written so far
    int        req_rises = 0;
    int        cycles    = 0;

    sdram_mux_top sdram_mux_top_inst (.*);

    // Handshake assertions inside the bank port
    bind bank_port sdram_mux_props props_inst (.*);

    always #5 clk = ~clk;

    always @(posedge sdram_req) req_rises++;  // One per bank access

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: clients did not finish within %0d cycles", CYCLE_LIMIT);
            stop_run();
        end
    end

    function automatic mem_addr_t bank_addr(int s, slot_addr_t a);
        mem_addr_t base;
        case (s)
            0:       base = 22'h10_0000;
            1:       base = 22'h00_0000;
            2:       base = 22'h00_8000;
            default: base = 22'h01_0000;
        endcase
        return base + mem_addr_t'(a);
    endfunction

    // Unwritten words read back as a pattern of the full address
    function automatic mem_data_t read_ref(mem_addr_t a);
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        return a[15:0] ^ {a[21:16], a[21:12]};
    endfunction

    function automatic mem_data_t merge_bytes(mem_data_t old, mem_data_t d, wr_mask_t m);
        mem_data_t r;
        r = old;
        if (!m[0]) begin
            r[7:0] = d[7:0];
        end
        if (!m[1]) begin
            r[15:8] = d[15:8];
        end
        return r;
    endfunction

    task automatic stop_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    // SDRAM controller with random ack delay
    task automatic sdram_model();
        mem_data_t word;
        forever begin
            @(negedge clk);
            if (sdram_req) begin
                repeat ($urandom_range(0, 5)) @(negedge clk);
                word = read_ref(sdram_addr);
                if (sdram_we) begin
                    // Only the RAM window takes writes
                    check("write sdram_addr[21:20]", sdram_addr[21:20], 2'b01);
                    word = merge_bytes(word, sdram_din, sdram_mask);
                    ref_mem[sdram_addr] = word;
                end
                sdram_rdata = word;  // Merged word on a write
                sdram_ack   = 1'b1;
                while (sdram_req) begin
                    @(negedge clk);
                end
                sdram_ack = 1'b0;
            end
        end
    endtask

    // Same address held, so ok stays up and the bank stays quiet
    task automatic hold_same_addr(int s);
        int start;
        @(negedge clk);
        cs[s]   = 1'b1;
        addr[s] = slot_addr_t'(s + 7);
        while (!ok[s]) begin
            @(negedge clk);
        end
        start = req_rises;
        repeat (10) begin
            @(negedge clk);
            check($sformatf("ok[%0d]", s), ok[s], 1'b1);
            check($sformatf("dout[%0d]", s), dout[s], read_ref(bank_addr(s, addr[s])));
        end
        check("sdram_req rises", req_rises, start);
        cs[s] = 1'b0;
    endtask

    task automatic run_client(int s);
        slot_addr_t a;
        logic       wr;
        mem_data_t  d;
        wr_mask_t   m;
        mem_data_t  exp_data;
        int         start;
        repeat (TXN_PER_SLOT) begin
            // RAM uses few addresses so reads land on earlier writes
            a  = (s == 0) ? slot_addr_t'($urandom_range(0, 15))
                          : slot_addr_t'($urandom) & 15'h703f;
            wr = (s == 0) && ($urandom_range(0, 1) == 1);
            d  = mem_data_t'($urandom);
            m  = wr_mask_t'($urandom);
            exp_data = read_ref(bank_addr(s, a));
            if (wr) begin
                exp_data = merge_bytes(exp_data, d, m);
            end
            @(negedge clk);
            cs[s]   = 1'b1;
            addr[s] = a;
            if (s == 0) begin
                ram_wen  = wr;
                ram_din  = d;
                ram_mask = m;
            end
            @(negedge clk);
            start = req_rises;  // pend visible from here
            while (!ok[s]) begin
                @(negedge clk);
            end
            check($sformatf("dout[%0d]", s), dout[s], exp_data);
            if (req_rises - start > 4) begin
                $display("Slot %0d waited %0d bank accesses, more than four",
                         s, req_rises - start);
                stop_run();
            end
            cs[s] = 1'b0;
            if (s == 0) begin
                ram_wen = 1'b0;
            end
        end
    endtask

    initial begin
        void'($urandom(32'h1f17));
        rst_n       = 1'b0;
        cs          = '0;
        ram_wen     = 1'b0;
        ram_din     = '0;
        ram_mask    = '1;
        sdram_ack   = 1'b0;
        sdram_rdata = '0;
        foreach (addr[i]) begin
            addr[i] = '0;
        end
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        fork
            sdram_model();
        join_none
        repeat (4) begin  // Quiet until some cs rises
            @(negedge clk);
            check("ok", ok, '0);
            check("sdram_req", sdram_req, 1'b0);
        end
        for (int s = 0; s < NUM_SLOTS; s++) begin
            hold_same_addr(s);
        end
        fork
            run_client(0);
            run_client(1);
            run_client(2);
            run_client(3);
        join
        repeat (4) @(negedge clk);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- test/sdram_mux_props.sv
//********************
// Bank handshake assertions, bound into bank_port
// by the testbench. Four-phase order and reset state.
//********************
`timescale 1ns/1ps

module sdram_mux_props import mem_pkg::*; (
    input logic      clk,
    input logic      rst_n,
    input logic      sdram_req,
    input logic      sdram_ack,
    input logic      sdram_we,
    input mem_addr_t sdram_addr,
    input mem_data_t sdram_din,
    input wr_mask_t  sdram_mask
);

    // Bus held steady until the controller answers
    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        sdram_req && !sdram_ack |=>
            sdram_req && $stable({sdram_addr, sdram_we, sdram_din, sdram_mask}))
        else $error("sdram_req or its bus changed before ack");

    req_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(sdram_req) |-> $past(sdram_ack))
        else $error("sdram_req fell without ack");

    req_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(sdram_req) |-> !$past(sdram_ack))
        else $error("sdram_req rose while ack was still high");

    reset_low: assert property (@(posedge clk) !rst_n |=> !sdram_req)
        else $error("sdram_req high after reset");

endmodule

//--- design/sdram_mux_top.sv
//********************
// Top of the slot layer.
// Four slot caches share one SDRAM bank through the
// arbiter and the bank port. Slot 0 is the CPU RAM.
//********************
`timescale 1ns/1ps

module sdram_mux_top import mem_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,

    // Clients
    input  logic [NUM_SLOTS-1:0] cs,
    input  slot_addr_t           addr [NUM_SLOTS],
    output mem_data_t            dout [NUM_SLOTS],
    output logic [NUM_SLOTS-1:0] ok,
    input  logic                 ram_wen,
    input  mem_data_t            ram_din,
    input  wr_mask_t             ram_mask,

    // SDRAM controller
    output logic                 sdram_req,
    output logic                 sdram_we,
    output mem_addr_t            sdram_addr,
    output mem_data_t            sdram_din,
    output wr_mask_t             sdram_mask,
    input  logic                 sdram_ack,
    input  mem_data_t            sdram_rdata
);

    logic [NUM_SLOTS-1:0] pend;
    logic [NUM_SLOTS-1:0] grant;
    bank_cmd_t            slot_cmds [NUM_SLOTS];
    logic                 cmd_valid;
    logic                 cmd_ready;
    bank_cmd_t            cmd;
    logic                 rsp_valid;
    bank_rsp_t            rsp;

    for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
        slot_cache #(
            .SLOT      ( slot_id_t'(i)                    )
        ) slot_cache_inst (
            .clk       ( clk                              ),
            .rst_n     ( rst_n                            ),
            .cs        ( cs[i]                            ),
            .wen       ( (i == 0) ? ram_wen  : 1'b0       ), // ROM slots never write
            .addr      ( addr[i]                          ),
            .din       ( (i == 0) ? ram_din  : mem_data_t'(0) ),
            .mask      ( (i == 0) ? ram_mask : wr_mask_t'('1) ),
            .dout      ( dout[i]                          ),
            .ok        ( ok[i]                            ),
            .pend      ( pend[i]                          ),
            .req_cmd   ( slot_cmds[i]                     ),
            .grant     ( grant[i]                         ),
            .rsp_valid ( rsp_valid                        ),
            .rsp       ( rsp                              )
        );
    end

    slot_arbiter slot_arbiter_inst (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .pend      ( pend      ),
        .slot_cmds ( slot_cmds ),
        .grant     ( grant     ),
        .cmd_valid ( cmd_valid ),
        .cmd       ( cmd       ),
        .cmd_ready ( cmd_ready )
    );

    bank_port bank_port_inst (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .cmd_valid   ( cmd_valid   ),
        .cmd         ( cmd         ),
        .cmd_ready   ( cmd_ready   ),
        .rsp_valid   ( rsp_valid   ),
        .rsp         ( rsp         ),
        .sdram_req   ( sdram_req   ),
        .sdram_we    ( sdram_we    ),
        .sdram_addr  ( sdram_addr  ),
        .sdram_din   ( sdram_din   ),
        .sdram_mask  ( sdram_mask  ),
        .sdram_ack   ( sdram_ack   ),
        .sdram_rdata ( sdram_rdata )
    );

endmodule

//--- design/bank_port.sv
//********************
// Bank side of the slot layer.
// Takes one command, adds the slot base address and runs
// the four-phase req/ack exchange with the SDRAM controller.
// The response goes back tagged with the slot id.
//********************
`timescale 1ns/1ps

module bank_port import mem_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cmd_valid,
    input  bank_cmd_t cmd,
    output logic      cmd_ready,
    output logic      rsp_valid,
    output bank_rsp_t rsp,
    output logic      sdram_req,
    output logic      sdram_we,
    output mem_addr_t sdram_addr,
    output mem_data_t sdram_din,
    output wr_mask_t  sdram_mask,
    input  logic      sdram_ack,
    input  mem_data_t sdram_rdata
);

    port_state_t state;
    logic        take;
    logic        done;

    assign cmd_ready = (state == IDLE);
    assign take      = cmd_valid && cmd_ready;
    assign done      = (state == REQ) && sdram_ack;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= IDLE;
            sdram_req <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (cmd_valid) begin
                        sdram_req <= 1'b1;
                        state     <= REQ;
                    end
                end
                REQ: begin
                    if (sdram_ack) begin  // rdata valid with ack
                        sdram_req <= 1'b0;
                        rsp_valid <= 1'b1;
                        state     <= RELEASE;
                    end
                end
                RELEASE: begin
                    // Next req only after ack is seen low
                    if (!sdram_ack) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Bus payload stays stable while req is high
    always_ff @(posedge clk) begin
        if (take) begin
            sdram_addr <= SLOT_OFFSET[cmd.slot] + mem_addr_t'(cmd.addr);
            sdram_we   <= cmd.we;
            sdram_din  <= cmd.din;
            sdram_mask <= cmd.mask;
            rsp.slot   <= cmd.slot;
        end
        if (done) begin
            rsp.data <= sdram_rdata;  // Merged word on a write
        end
    end

endmodule

//--- design/slot_arbiter.sv
//********************
// Round-robin arbiter over the slot caches.
// Grants one pending slot at a time and keeps its
// command in a one-entry register until the bank port takes it.
//********************
`timescale 1ns/1ps

module slot_arbiter import mem_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [NUM_SLOTS-1:0] pend,
    input  bank_cmd_t            slot_cmds [NUM_SLOTS],
    output logic [NUM_SLOTS-1:0] grant,
    output logic                 cmd_valid,
    output bank_cmd_t            cmd,
    input  logic                 cmd_ready
);

    slot_id_t             last;     // Last winner
    slot_id_t             win;
    slot_id_t             idx;
    logic                 found;
    logic [NUM_SLOTS-1:0] eligible;
    logic                 load;

    // A slot still seeing its grant keeps pend for one more cycle
    assign eligible = pend & ~grant;

    // First eligible slot after the last winner
    always_comb begin
        win   = last;
        found = 1'b0;
        for (int i = 1; i <= NUM_SLOTS; i++) begin
            idx = slot_id_t'(last + slot_id_t'(i));
            if (!found && eligible[idx]) begin
                win   = idx;
                found = 1'b1;
            end
        end
    end

    assign load = found && (!cmd_valid || cmd_ready);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            grant     <= '0;
            cmd_valid <= 1'b0;
            last      <= '0;
        end else begin
            grant <= '0;  // One-cycle pulse
            if (load) begin
                grant[win] <= 1'b1;
                cmd_valid  <= 1'b1;
                last       <= win;
            end else if (cmd_ready) begin
                cmd_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            cmd <= slot_cmds[win];
        end
    end

endmodule

//--- design/slot_cache.sv
//********************
// One client slot with a single-entry cache.
// Holds the last address and data; a match raises ok,
// a miss or a write posts a command for the arbiter.
//********************
`timescale 1ns/1ps

module slot_cache import mem_pkg::*; #(
    parameter slot_id_t SLOT = '0
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cs,
    input  logic       wen,
    input  slot_addr_t addr,
    input  mem_data_t  din,
    input  wr_mask_t   mask,
    output mem_data_t  dout,
    output logic       ok,
    output logic       pend,
    output bank_cmd_t  req_cmd,
    input  logic       grant,
    input  logic       rsp_valid,
    input  bank_rsp_t  rsp
);

    logic       valid;
    logic       wait_rsp;   // Granted and waiting for its response
    logic       wr_done;    // Current write already finished
    slot_addr_t cache_addr;
    mem_data_t  merged;
    logic       match;
    logic       hit;
    logic       rsp_hit;
    logic       fill_ok;

    assign match   = valid && (cache_addr == addr);
    assign hit     = match && (!wen || wr_done);  // Writes hit only once done
    assign rsp_hit = rsp_valid && (rsp.slot == SLOT);
    assign fill_ok = rsp_hit && (req_cmd.addr == addr) && (req_cmd.we || !wen);

    // Bytes with a low mask bit take the written data
    assign merged[15:8] = (req_cmd.we && !req_cmd.mask[1]) ? req_cmd.din[15:8] : rsp.data[15:8];
    assign merged[7:0]  = (req_cmd.we && !req_cmd.mask[0]) ? req_cmd.din[7:0]  : rsp.data[7:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid    <= 1'b0;
            wait_rsp <= 1'b0;
            wr_done  <= 1'b0;
            pend     <= 1'b0;
            ok       <= 1'b0;
        end else begin
            ok <= cs && (hit || fill_ok);
            if (grant) begin
                pend     <= 1'b0;
                wait_rsp <= 1'b1;
            end else if (cs && !hit && !pend && !wait_rsp) begin
                pend <= 1'b1;
            end
            if (rsp_hit) begin
                valid    <= 1'b1;
                wait_rsp <= 1'b0;
                wr_done  <= req_cmd.we;
            end else begin
                // Cleared once the client leaves the finished write
                wr_done <= wr_done && cs && wen && (addr == cache_addr);
            end
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (cs && !hit && !pend && !wait_rsp) begin
            req_cmd <= '{slot: SLOT, addr: addr, we: wen, din: din, mask: mask};
        end
        if (rsp_hit) begin
            cache_addr <= req_cmd.addr;
            dout       <= merged;
        end
    end

endmodule

//--- design/mem_pkg.sv
//********************
// Shared types and constants of the SDRAM slot layer.
// Fixed at four 16-bit slots on one bank. Every RTL file
// imports this package in its module header.
//********************
package mem_pkg;

    localparam int NUM_SLOTS = 4;

    typedef logic [1:0]  slot_id_t;   // Slot index
    typedef logic [21:0] mem_addr_t;  // SDRAM word address
    typedef logic [14:0] slot_addr_t; // Slot-local word address
    typedef logic [15:0] mem_data_t;
    typedef logic [1:0]  wr_mask_t;   // One active-low bit per byte

    // Fixed base of each slot inside the bank
    localparam mem_addr_t SLOT_OFFSET [NUM_SLOTS] = '{
        22'h10_0000,  // CPU work RAM
        22'h00_0000,  // Char ROM
        22'h00_8000,  // Scroll 1 ROM
        22'h01_0000   // Scroll 2 ROM
    };

    // Request from a slot towards the bank
    typedef struct packed {
        slot_id_t   slot;
        slot_addr_t addr;
        logic       we;
        mem_data_t  din;
        wr_mask_t   mask;
    } bank_cmd_t;

    // Response routed back to the owning slot
    typedef struct packed {
        slot_id_t  slot;
        mem_data_t data;
    } bank_rsp_t;

    // Four-phase handshake states of the bank port
    typedef enum logic [1:0] {
        IDLE,
        REQ,
        RELEASE
    } port_state_t;

endpackage
